// ==== common/bram_pkg.sv ====
package bram_pkg;

  localparam logic [15:0] FPGA_VERSION = 16'h00a1;

  localparam int MOD_ADDR_W = 8;
  localparam int STM_ADDR_W = 8;
  localparam int STM_PAGE_W = 2;
  localparam int BUS_ADDR_W = 14;

  // top two word address bits of the CPU bus.
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'd0,
    SEL_MOD        = 2'd1,
    SEL_PWE_TABLE  = 2'd2,
    SEL_STM        = 2'd3
  } bram_select_e;

  // Register map of the controller bank, low 8 bits of the word address.
  typedef enum logic [7:0] {
    ADDR_VERSION            = 8'h00,
    ADDR_MOD_MEM_WR_SEGMENT = 8'h01,
    ADDR_MOD_REQ_RD_SEGMENT = 8'h02,
    ADDR_MOD_CYCLE          = 8'h03,
    ADDR_MOD_FREQ_DIV       = 8'h04,
    ADDR_STM_MEM_WR_SEGMENT = 8'h05,
    ADDR_STM_MEM_WR_PAGE    = 8'h06,
    ADDR_STM_MODE           = 8'h07,
    ADDR_STM_REQ_RD_SEGMENT = 8'h08,
    ADDR_STM_CYCLE          = 8'h09,
    ADDR_STM_FREQ_DIV       = 8'h0a,
    ADDR_STM_NUM_FOCI       = 8'h0b,
    ADDR_STM_SOUND_SPEED    = 8'h0c
  } ctrl_addr_e;

  // one bus access, valid for a single cycle.
  typedef struct packed {
    logic                  valid;
    bram_select_e          sel;
    logic [BUS_ADDR_W-1:0] addr;
    logic [15:0]           data;
  } bus_cmd_t;

  typedef struct packed {
    logic        req_rd_segment;
    logic [15:0] cycle;
    logic [15:0] freq_div;
  } mod_settings_t;

  typedef struct packed {
    logic        mode;
    logic        req_rd_segment;
    logic [15:0] cycle;
    logic [15:0] freq_div;
    logic [7:0]  num_foci;
    logic [15:0] sound_speed;
  } stm_settings_t;

endpackage

// ==== hw/bus_decode.sv ====
`timescale 1ns/1ps
module bus_decode (
  input  logic               CPU_CKIO,
  input  logic               reset,
  input  logic [16:0]        cpu_addr,
  input  logic [15:0]        cpu_data_in,
  input  logic               cpu_cn,
  input  logic               cpu_we0_n,
  input  logic               cpu_rd_n,
  output bram_pkg::bus_cmd_t wr_cmd,
  output bram_pkg::bus_cmd_t rd_cmd
);
  import bram_pkg::*;

  logic [16:0] addr_q;
  logic [15:0] data_q;
  logic        wr_act_q;
  logic        wr_act_qq;
  logic        rd_act_q;
  logic        rd_act_qq;

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data_in;
    wr_cmd.sel  <= bram_select_e'(addr_q[16:15]);
    wr_cmd.addr <= addr_q[14:1]; // byte lane bit 0 is dropped.
    wr_cmd.data <= data_q;
    rd_cmd.sel  <= bram_select_e'(addr_q[16:15]);
    rd_cmd.addr <= addr_q[14:1];
    rd_cmd.data <= data_q;
    if (reset) begin
      wr_act_q     <= 1'b0;
      wr_act_qq    <= 1'b0;
      rd_act_q     <= 1'b0;
      rd_act_qq    <= 1'b0;
      wr_cmd.valid <= 1'b0;
      rd_cmd.valid <= 1'b0;
    end else begin
      wr_act_q     <= ~cpu_cn & ~cpu_we0_n;
      wr_act_qq    <= wr_act_q;
      rd_act_q     <= ~cpu_cn & ~cpu_rd_n;
      rd_act_qq    <= rd_act_q;
      wr_cmd.valid <= wr_act_q & ~wr_act_qq; // one pulse per strobe.
      rd_cmd.valid <= rd_act_q & ~rd_act_qq;
    end
  end

  // The CPU never drives both strobes in one access.
  assert property (@(posedge CPU_CKIO) disable iff (reset)
    !(wr_cmd.valid && rd_cmd.valid));

endmodule

// ==== hw/ctrl_regs.sv ====
`timescale 1ns/1ps
module ctrl_regs (
  input  logic                              CPU_CKIO,
  input  logic                              reset,
  input  bram_pkg::bus_cmd_t                wr_cmd,
  input  bram_pkg::bus_cmd_t                rd_cmd,
  output logic                              mod_wr_segment,
  output logic                              stm_wr_segment,
  output logic [bram_pkg::STM_PAGE_W-1:0]   stm_wr_page,
  output bram_pkg::mod_settings_t           mod_settings,
  output bram_pkg::stm_settings_t           stm_settings,
  output logic [15:0]                       ctrl_rd_data
);
  import bram_pkg::*;

  logic       wr_hit;
  logic       rd_hit;
  ctrl_addr_e wr_reg;
  ctrl_addr_e rd_reg;
  logic [15:0] rd_word;

  assign wr_hit = wr_cmd.valid && (wr_cmd.sel == SEL_CONTROLLER);
  assign rd_hit = rd_cmd.valid && (rd_cmd.sel == SEL_CONTROLLER);
  assign wr_reg = ctrl_addr_e'(wr_cmd.addr[7:0]);
  assign rd_reg = ctrl_addr_e'(rd_cmd.addr[7:0]);

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= '0;
      mod_settings   <= '0;
      stm_settings   <= '0;
    end else if (wr_hit) begin
      case (wr_reg)
        ADDR_MOD_MEM_WR_SEGMENT: mod_wr_segment <= wr_cmd.data[0];
        ADDR_MOD_REQ_RD_SEGMENT: mod_settings.req_rd_segment <= wr_cmd.data[0];
        ADDR_MOD_CYCLE:          mod_settings.cycle <= wr_cmd.data;
        ADDR_MOD_FREQ_DIV:       mod_settings.freq_div <= wr_cmd.data;
        ADDR_STM_MEM_WR_SEGMENT: stm_wr_segment <= wr_cmd.data[0];
        ADDR_STM_MEM_WR_PAGE:    stm_wr_page <= wr_cmd.data[STM_PAGE_W-1:0];
        ADDR_STM_MODE:           stm_settings.mode <= wr_cmd.data[0];
        ADDR_STM_REQ_RD_SEGMENT: stm_settings.req_rd_segment <= wr_cmd.data[0];
        ADDR_STM_CYCLE:          stm_settings.cycle <= wr_cmd.data;
        ADDR_STM_FREQ_DIV:       stm_settings.freq_div <= wr_cmd.data;
        ADDR_STM_NUM_FOCI:       stm_settings.num_foci <= wr_cmd.data[7:0];
        ADDR_STM_SOUND_SPEED:    stm_settings.sound_speed <= wr_cmd.data;
        default: ; // version and unmapped addresses are read-only.
      endcase
    end
  end

  always_comb begin
    case (rd_reg)
      ADDR_VERSION:            rd_word = FPGA_VERSION;
      ADDR_MOD_MEM_WR_SEGMENT: rd_word = {15'd0, mod_wr_segment};
      ADDR_MOD_REQ_RD_SEGMENT: rd_word = {15'd0, mod_settings.req_rd_segment};
      ADDR_MOD_CYCLE:          rd_word = mod_settings.cycle;
      ADDR_MOD_FREQ_DIV:       rd_word = mod_settings.freq_div;
      ADDR_STM_MEM_WR_SEGMENT: rd_word = {15'd0, stm_wr_segment};
      ADDR_STM_MEM_WR_PAGE:    rd_word = {{(16 - STM_PAGE_W){1'b0}}, stm_wr_page};
      ADDR_STM_MODE:           rd_word = {15'd0, stm_settings.mode};
      ADDR_STM_REQ_RD_SEGMENT: rd_word = {15'd0, stm_settings.req_rd_segment};
      ADDR_STM_CYCLE:          rd_word = stm_settings.cycle;
      ADDR_STM_FREQ_DIV:       rd_word = stm_settings.freq_div;
      ADDR_STM_NUM_FOCI:       rd_word = {8'd0, stm_settings.num_foci};
      ADDR_STM_SOUND_SPEED:    rd_word = stm_settings.sound_speed;
      default:                 rd_word = 16'd0;
    endcase
  end

  always_ff @(posedge CPU_CKIO) begin
    if (reset) ctrl_rd_data <= 16'd0;
    else if (rd_hit) ctrl_rd_data <= rd_word;
  end

  // the write page moves only after a page register write.
  assert property (@(posedge CPU_CKIO) disable iff (reset)
    $changed(stm_wr_page) |-> $past(wr_hit && (wr_reg == ADDR_STM_MEM_WR_PAGE)));

endmodule

// ==== mod_mem/mod_mem.sv ====
`timescale 1ns/1ps
module mod_mem (
  input  logic               CPU_CKIO,
  input  logic               reset,
  input  bram_pkg::bus_cmd_t wr_cmd,
  input  bram_pkg::bus_cmd_t rd_cmd,
  input  logic               mod_wr_segment,
  output logic [15:0]        mod_rd_data
);
  import bram_pkg::*;

  logic [15:0] mem [2**(MOD_ADDR_W + 1)];

  logic [MOD_ADDR_W:0] wr_idx;
  logic [MOD_ADDR_W:0] rd_idx;
  logic                wr_hit;
  logic                rd_hit;

  // upper address bits alias onto the segment.
  assign wr_idx = {mod_wr_segment, wr_cmd.addr[MOD_ADDR_W-1:0]};
  assign rd_idx = {mod_wr_segment, rd_cmd.addr[MOD_ADDR_W-1:0]};

  assign wr_hit = wr_cmd.valid && (wr_cmd.sel == SEL_MOD);
  assign rd_hit = rd_cmd.valid && (rd_cmd.sel == SEL_MOD);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_hit) begin
      mem[wr_idx] <= wr_cmd.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      mod_rd_data <= 16'd0;
    end else if (rd_hit) begin
      mod_rd_data <= mem[rd_idx]; // the playback side reads through its own port.
    end
  end

endmodule

// ==== stm_mem/stm_mem.sv ====
`timescale 1ns/1ps
module stm_mem (
  input  logic                            CPU_CKIO,
  input  logic                            reset,
  input  bram_pkg::bus_cmd_t              wr_cmd,
  input  bram_pkg::bus_cmd_t              rd_cmd,
  input  logic                            stm_wr_segment,
  input  logic [bram_pkg::STM_PAGE_W-1:0] stm_wr_page,
  output logic [15:0]                     stm_rd_data
);
  import bram_pkg::*;

  localparam int IDX_W = 1 + STM_PAGE_W + STM_ADDR_W;

  logic [15:0] mem [2**IDX_W];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             wr_hit;
  logic             rd_hit;

  // the page register extends the bus window. one window reaches every page.
  assign wr_idx = {stm_wr_segment, stm_wr_page, wr_cmd.addr[STM_ADDR_W-1:0]};
  assign rd_idx = {stm_wr_segment, stm_wr_page, rd_cmd.addr[STM_ADDR_W-1:0]};

  assign wr_hit = wr_cmd.valid && (wr_cmd.sel == SEL_STM);
  assign rd_hit = rd_cmd.valid && (rd_cmd.sel == SEL_STM);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_hit) begin
      mem[wr_idx] <= wr_cmd.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      stm_rd_data <= 16'd0;
    end else if (rd_hit) begin
      stm_rd_data <= mem[rd_idx];
    end
  end

  // A write from the decode stage always names a known block.
  assert property (@(posedge CPU_CKIO) disable iff (reset)
    wr_cmd.valid |-> !$isunknown(wr_cmd.sel));

endmodule

// ==== hw/readback_mux.sv ====
`timescale 1ns/1ps
module readback_mux (
  input  logic               CPU_CKIO,
  input  logic               reset,
  input  bram_pkg::bus_cmd_t rd_cmd,
  input  logic [15:0]        ctrl_rd_data,
  input  logic [15:0]        mod_rd_data,
  input  logic [15:0]        stm_rd_data,
  output logic [15:0]        cpu_data_out
);
  import bram_pkg::*;

  bram_select_e rd_sel_q;
  logic         rd_valid_q;

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      rd_sel_q     <= SEL_CONTROLLER;
      rd_valid_q   <= 1'b0;
      cpu_data_out <= 16'd0;
    end else begin
      rd_sel_q   <= rd_cmd.sel; // lines up with the one cycle read in each block.
      rd_valid_q <= rd_cmd.valid;
      if (rd_valid_q) begin
        case (rd_sel_q)
          SEL_CONTROLLER: cpu_data_out <= ctrl_rd_data;
          SEL_MOD:        cpu_data_out <= mod_rd_data;
          SEL_STM:        cpu_data_out <= stm_rd_data;
          default:        cpu_data_out <= 16'd0; // no table storage behind this select.
        endcase
      end
    end
  end

endmodule

// ==== hw/bram_top.sv ====
`timescale 1ns/1ps
module bram_top (
  input  logic                    CPU_CKIO,
  input  logic                    reset,
  input  logic [16:0]             cpu_addr,
  input  logic [15:0]             cpu_data_in,
  input  logic                    cpu_cn,
  input  logic                    cpu_we0_n,
  input  logic                    cpu_rd_n,
  output logic [15:0]             cpu_data_out,
  output bram_pkg::mod_settings_t mod_settings,
  output bram_pkg::stm_settings_t stm_settings
);
  import bram_pkg::*;

  bus_cmd_t              wr_cmd;
  bus_cmd_t              rd_cmd;
  logic                  mod_wr_segment;
  logic                  stm_wr_segment;
  logic [STM_PAGE_W-1:0] stm_wr_page;
  logic [15:0]           ctrl_rd_data;
  logic [15:0]           mod_rd_data;
  logic [15:0]           stm_rd_data;

  bus_decode i_bus_decode (
    .CPU_CKIO    (CPU_CKIO),
    .reset       (reset),
    .cpu_addr    (cpu_addr),
    .cpu_data_in (cpu_data_in),
    .cpu_cn      (cpu_cn),
    .cpu_we0_n   (cpu_we0_n),
    .cpu_rd_n    (cpu_rd_n),
    .wr_cmd      (wr_cmd),
    .rd_cmd      (rd_cmd)
  );

  ctrl_regs i_ctrl_regs (
    .CPU_CKIO       (CPU_CKIO),
    .reset          (reset),
    .wr_cmd         (wr_cmd),
    .rd_cmd         (rd_cmd),
    .mod_wr_segment (mod_wr_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .mod_settings   (mod_settings),
    .stm_settings   (stm_settings),
    .ctrl_rd_data   (ctrl_rd_data)
  );

  mod_mem i_mod_mem (
    .CPU_CKIO       (CPU_CKIO),
    .reset          (reset),
    .wr_cmd         (wr_cmd),
    .rd_cmd         (rd_cmd),
    .mod_wr_segment (mod_wr_segment),
    .mod_rd_data    (mod_rd_data)
  );

  stm_mem i_stm_mem (
    .CPU_CKIO       (CPU_CKIO),
    .reset          (reset),
    .wr_cmd         (wr_cmd),
    .rd_cmd         (rd_cmd),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .stm_rd_data    (stm_rd_data)
  );

  readback_mux i_readback_mux (
    .CPU_CKIO     (CPU_CKIO),
    .reset        (reset),
    .rd_cmd       (rd_cmd),
    .ctrl_rd_data (ctrl_rd_data),
    .mod_rd_data  (mod_rd_data),
    .stm_rd_data  (stm_rd_data),
    .cpu_data_out (cpu_data_out)
  );

endmodule

// ==== verif/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

task automatic write_access(input logic [1:0] sel, input logic [13:0] addr,
                            input logic [15:0] data);
  @(posedge CPU_CKIO);
  cpu_addr    <= {sel, addr, 1'b0}; // byte address, bit 0 unused.
  cpu_data_in <= data;
  cpu_cn      <= 1'b0;
  cpu_we0_n   <= 1'b0;
  repeat (3) @(posedge CPU_CKIO);
  cpu_cn    <= 1'b1;
  cpu_we0_n <= 1'b1;
  repeat (2) @(posedge CPU_CKIO);
endtask

task automatic read_access(input logic [1:0] sel, input logic [13:0] addr,
                           output logic [15:0] data);
  @(posedge CPU_CKIO);
  cpu_addr <= {sel, addr, 1'b0};
  cpu_cn   <= 1'b0;
  cpu_rd_n <= 1'b0;
  repeat (4) @(posedge CPU_CKIO); // decode, block read, result register.
  @(negedge CPU_CKIO);
  data = cpu_data_out;
  @(posedge CPU_CKIO);
  cpu_cn   <= 1'b1;
  cpu_rd_n <= 1'b1;
  repeat (2) @(posedge CPU_CKIO);
endtask

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected) begin
    $display("ERR %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch");
  end
endtask

// galois form, taps 32 22 2 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) return (state >> 1) ^ 32'h8020_0003;
  return state >> 1;
endfunction

function automatic logic [15:0] random_word();
  logic [15:0] word;
  word = '0;
  for (int i = 0; i < 16; i++) begin
    lfsr_state = lfsr_next(lfsr_state); // one step for each bit taken.
    word = {word[14:0], lfsr_state[0]};
  end
  return word;
endfunction

`endif

// ==== verif/tb_bram_top.sv ====
`timescale 1ns/1ps
module tb_bram_top;
  import bram_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 10;
  localparam bit WR = 1'b1;
  localparam bit RD = 1'b0;

  typedef struct packed {
    logic        is_wr;
    logic        chk;  // compare the settings field after the write.
    logic [1:0]  sel;
    logic [13:0] addr;
    logic [15:0] data;
    logic [15:0] exp;
  } step_t;

  logic          CPU_CKIO = 1'b0;
  logic          reset;
  logic [16:0]   cpu_addr;
  logic [15:0]   cpu_data_in;
  logic          cpu_cn;
  logic          cpu_we0_n;
  logic          cpu_rd_n;
  logic [15:0]   cpu_data_out;
  mod_settings_t mod_settings;
  stm_settings_t stm_settings;

  logic [31:0] lfsr_state = 32'd83882;
  logic [15:0] rand_words [11];
  step_t       steps [$];
  logic        table_ready = 1'b0;

  `include "tb_bus_tasks.svh"

  bram_top i_dut (
    .CPU_CKIO     (CPU_CKIO),
    .reset        (reset),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_rd_n     (cpu_rd_n),
    .cpu_data_out (cpu_data_out),
    .mod_settings (mod_settings),
    .stm_settings (stm_settings)
  );

  always #(CLK_PERIOD / 2) CPU_CKIO = ~CPU_CKIO;

  function automatic void add_step(input logic is_wr, input logic chk, input bram_select_e sel,
                                   input logic [13:0] addr, input logic [15:0] data,
                                   input logic [15:0] exp);
    step_t s;
    s = {is_wr, chk, sel, addr, data, exp};
    steps.push_back(s);
  endfunction

  // settings field behind a controller register, zero extended.
  task automatic settings_field(input logic [13:0] addr, output string name,
                                output logic [15:0] value);
    name  = "unmapped register";
    value = 16'd0;
    case (addr[7:0])
      ADDR_MOD_REQ_RD_SEGMENT: begin
        name  = "mod_settings.req_rd_segment";
        value = {15'd0, mod_settings.req_rd_segment};
      end
      ADDR_MOD_CYCLE: begin
        name  = "mod_settings.cycle";
        value = mod_settings.cycle;
      end
      ADDR_MOD_FREQ_DIV: begin
        name  = "mod_settings.freq_div";
        value = mod_settings.freq_div;
      end
      ADDR_STM_MODE: begin
        name  = "stm_settings.mode";
        value = {15'd0, stm_settings.mode};
      end
      ADDR_STM_REQ_RD_SEGMENT: begin
        name  = "stm_settings.req_rd_segment";
        value = {15'd0, stm_settings.req_rd_segment};
      end
      ADDR_STM_CYCLE: begin
        name  = "stm_settings.cycle";
        value = stm_settings.cycle;
      end
      ADDR_STM_FREQ_DIV: begin
        name  = "stm_settings.freq_div";
        value = stm_settings.freq_div;
      end
      ADDR_STM_NUM_FOCI: begin
        name  = "stm_settings.num_foci";
        value = {8'd0, stm_settings.num_foci};
      end
      ADDR_STM_SOUND_SPEED: begin
        name  = "stm_settings.sound_speed";
        value = stm_settings.sound_speed;
      end
      default: ;
    endcase
  endtask

  function automatic void build_table();
    add_step(RD, 0, SEL_CONTROLLER, ADDR_VERSION, 16'h0000, FPGA_VERSION);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_VERSION, 16'hffff, 16'h0000);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_VERSION, 16'h0000, FPGA_VERSION);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'h0003, 16'h0001);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_MOD_CYCLE, rand_words[0], rand_words[0]);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_MOD_FREQ_DIV, rand_words[1], rand_words[1]);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_MODE, 16'h0005, 16'h0001);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_REQ_RD_SEGMENT, 16'h8001, 16'h0001);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_CYCLE, rand_words[2], rand_words[2]);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_FREQ_DIV, rand_words[3], rand_words[3]);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_NUM_FOCI, 16'h5a3c, 16'h003c);
    add_step(WR, 1, SEL_CONTROLLER, ADDR_STM_SOUND_SPEED, rand_words[4], rand_words[4]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_MOD_REQ_RD_SEGMENT, 16'h0000, 16'h0001);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_MOD_CYCLE, 16'h0000, rand_words[0]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_MOD_FREQ_DIV, 16'h0000, rand_words[1]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_MODE, 16'h0000, 16'h0001);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_CYCLE, 16'h0000, rand_words[2]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_REQ_RD_SEGMENT, 16'h0000, 16'h0001);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_FREQ_DIV, 16'h0000, rand_words[3]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_NUM_FOCI, 16'h0000, 16'h003c);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_SOUND_SPEED, 16'h0000, rand_words[4]);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0007, 16'h0000);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0000, 16'h0003);
    // same modulation address under both segments.
    add_step(WR, 0, SEL_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 16'h0000);
    add_step(WR, 0, SEL_MOD, 14'h0012, rand_words[5], 16'h0000);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, 16'h0000);
    add_step(WR, 0, SEL_MOD, 14'h0012, rand_words[6], 16'h0000);
    add_step(RD, 0, SEL_MOD, 14'h0012, 16'h0000, rand_words[6]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 16'h0001);
    add_step(RD, 0, SEL_MOD, 14'h3f12, 16'h0000, rand_words[6]);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 16'h0000);
    add_step(RD, 0, SEL_MOD, 14'h0012, 16'h0000, rand_words[5]);
    // one in-page address under two pages and both segments.
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0000, 16'h0000);
    add_step(WR, 0, SEL_STM, 14'h0034, rand_words[7], 16'h0000);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0002, 16'h0000);
    add_step(WR, 0, SEL_STM, 14'h0034, rand_words[8], 16'h0000);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_SEGMENT, 16'h0001, 16'h0000);
    add_step(WR, 0, SEL_STM, 14'h0034, rand_words[9], 16'h0000);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0000, 16'h0000);
    add_step(WR, 0, SEL_STM, 14'h0034, rand_words[10], 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h0034, 16'h0000, rand_words[10]);
    add_step(RD, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0000, 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h1f34, 16'h0000, rand_words[10]);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0002, 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h0034, 16'h0000, rand_words[9]);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_SEGMENT, 16'h0000, 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h0034, 16'h0000, rand_words[8]);
    add_step(WR, 0, SEL_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0000, 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h0034, 16'h0000, rand_words[7]);
    add_step(WR, 0, SEL_PWE_TABLE, 14'h0010, 16'hbeef, 16'h0000);
    add_step(RD, 0, SEL_PWE_TABLE, 14'h0010, 16'h0000, 16'h0000);
    add_step(RD, 0, SEL_STM, 14'h0034, 16'h0000, rand_words[7]);
    add_step(RD, 0, SEL_CONTROLLER, 14'h003f, 16'h0000, 16'h0000);
  endfunction

  initial begin
    step_t       s;
    logic [15:0] got;
    string       field;
    logic [15:0] value;
    reset       = 1'b1;
    cpu_addr    = '0;
    cpu_data_in = '0;
    cpu_cn      = 1'b1;
    cpu_we0_n   = 1'b1;
    cpu_rd_n    = 1'b1;
    foreach (rand_words[i]) rand_words[i] = random_word();
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge CPU_CKIO);
    reset <= 1'b0;
    @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    check_value("cpu_data_out", 64'(cpu_data_out), 64'd0);
    check_value("mod_settings", 64'(mod_settings), 64'd0);
    check_value("stm_settings", 64'(stm_settings), 64'd0);
    foreach (steps[i]) begin
      s = steps[i];
      if (s.is_wr) begin
        write_access(s.sel, s.addr, s.data);
        if (s.chk) begin
          @(negedge CPU_CKIO);
          settings_field(s.addr, field, value);
          check_value(field, 64'(value), 64'(s.exp));
        end
      end else begin
        read_access(s.sel, s.addr, got);
        check_value("cpu_data_out", 64'(got), 64'(s.exp));
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

  // no bus access takes more than 8 cycles.
  initial begin
    wait (table_ready);
    #((RESET_CYCLES + steps.size() * 8) * CLK_PERIOD);
    $display("tests did not finish within %0d cycles", RESET_CYCLES + steps.size() * 8);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

// ==== src.f ====
+incdir+verif
common/bram_pkg.sv
hw/bus_decode.sv
hw/ctrl_regs.sv
mod_mem/mod_mem.sv
stm_mem/stm_mem.sv
hw/readback_mux.sv
hw/bram_top.sv
verif/tb_bram_top.sv
